/* verilog/sdr_pkg.sv */
package sdr_pkg;

   // SDRAM geometry, one 16-bit part
   localparam int DATA_W      = 16;
   localparam int SEL_W       = DATA_W / 8;             // Byte lanes
   localparam int COL_W       = 9;
   localparam int ROW_W       = 13;                     // Also the SDRAM address bus width
   localparam int BA_W        = 2;
   localparam int ADDR_W      = COL_W + ROW_W + BA_W;   // Word address {row, bank, col}
   localparam int LINE_LOG    = 3;                      // 8 words per line and per burst
   localparam int LINE_ADDR_W = ADDR_W - LINE_LOG;

   // Captured Wishbone access
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic              we;
      logic [SEL_W-1:0]  sel;
      logic [DATA_W-1:0] wdata;
   } cpu_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              done;   // One-cycle completion
   } cpu_rsp_t;

   typedef struct packed {
      logic                   rd;     // 1 read burst, 0 write burst
      logic [LINE_ADDR_W-1:0] line;
   } burst_cmd_t;

   // SDRAM command bus
   typedef struct packed {
      logic             cs_n;
      logic             ras_n;
      logic             cas_n;
      logic             we_n;
      logic [BA_W-1:0]  ba;
      logic [ROW_W-1:0] addr;
   } sdr_cmd_t;

   // Command patterns as {cs_n, ras_n, cas_n, we_n}
   localparam logic [3:0] CMD_NOP        = 4'b0111;
   localparam logic [3:0] CMD_ACTIVE     = 4'b0011;
   localparam logic [3:0] CMD_READ       = 4'b0101;
   localparam logic [3:0] CMD_WRITE      = 4'b0100;
   localparam logic [3:0] CMD_PRECHARGE  = 4'b0010;
   localparam logic [3:0] CMD_REFRESH    = 4'b0001;
   localparam logic [3:0] CMD_LOAD_MODE  = 4'b0000;
   localparam logic [3:0] CMD_BURST_TERM = 4'b0110;

endpackage

/* verilog/wb_slave_port.sv */
`timescale 1ns/1ns

module wb_slave_port import sdr_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              wb_cyc,
   input  logic              wb_stb,
   input  logic              wb_we,
   input  logic [ADDR_W-1:0] wb_adr,
   input  logic [SEL_W-1:0]  wb_sel,
   input  logic [DATA_W-1:0] wb_dat_w,
   output logic [DATA_W-1:0] wb_dat_r,
   output logic              wb_ack,
   output cpu_req_t          req,
   output logic              req_valid,
   input  cpu_rsp_t          rsp
);

   logic hold_q;   // Access done, stb not yet released
   logic accept;

   // New access only when nothing is in flight
   assign accept = wb_cyc && wb_stb && !req_valid && !hold_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_valid <= 1'b0;
         wb_ack    <= 1'b0;
         hold_q    <= 1'b0;
      end else begin
         wb_ack <= rsp.done;                 // Exactly one cycle per access
         if (accept)
            req_valid <= 1'b1;
         else if (rsp.done)
            req_valid <= 1'b0;
         // Master keeps stb up one cycle past ack
         if (rsp.done)
            hold_q <= 1'b1;
         else if (!(wb_cyc && wb_stb))
            hold_q <= 1'b0;
      end
   end

   // Captured access and read data
   always_ff @(posedge clk) begin
      if (accept)
         req <= '{addr: wb_adr, we: wb_we, sel: wb_sel, wdata: wb_dat_w};
      if (rsp.done)
         wb_dat_r <= rsp.rdata;
   end

endmodule

/* verilog/line_buffer.sv */
`timescale 1ns/1ns

module line_buffer import sdr_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  cpu_req_t          req,
   input  logic              req_valid,
   output cpu_rsp_t          rsp,
   output burst_cmd_t        burst,
   output logic              burst_req,
   input  logic              burst_ack,
   input  logic              wr_rdy,
   output logic [DATA_W-1:0] wr_data,
   input  logic              rd_vld,
   input  logic [DATA_W-1:0] rd_data
);

   localparam int WORDS = 1 << LINE_LOG;

   typedef enum logic [1:0] {B_IDLE, B_EVICT, B_FILL} state_t;

   state_t                 state_q;
   logic [DATA_W-1:0]      mem [WORDS];   // The line itself
   logic [LINE_ADDR_W-1:0] tag_q;
   logic                   valid_q;
   logic                   dirty_q;
   logic [LINE_LOG-1:0]    idx_q;         // Burst word index
   logic                   acked_q;       // burst_ack seen high
   logic                   done_q;
   logic [DATA_W-1:0]      rdata_q;
   burst_cmd_t             burst_q;
   logic [LINE_ADDR_W-1:0] req_line;
   logic [LINE_LOG-1:0]    req_idx;
   logic                   hit;
   logic                   start;
   logic                   burst_done;

   assign req_line   = req.addr[ADDR_W-1:LINE_LOG];
   assign req_idx    = req.addr[LINE_LOG-1:0];
   assign hit        = valid_q && (tag_q == req_line);
   // Skip the cycle where done is still out
   assign start      = (state_q == B_IDLE) && req_valid && !done_q;
   assign burst_done = acked_q && !burst_ack;   // Ack fell, controller finished

   assign rsp   = '{rdata: rdata_q, done: done_q};
   assign burst = burst_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q   <= B_IDLE;
         valid_q   <= 1'b0;
         dirty_q   <= 1'b0;
         idx_q     <= '0;
         acked_q   <= 1'b0;
         done_q    <= 1'b0;
         burst_req <= 1'b0;
         burst_q   <= '0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            B_IDLE: begin
               if (start) begin
                  if (hit) begin
                     done_q <= 1'b1;
                     if (req.we)
                        dirty_q <= 1'b1;
                  end else begin
                     idx_q     <= '0;
                     burst_req <= 1'b1;
                     if (valid_q && dirty_q) begin
                        // Old line goes back first
                        burst_q <= '{rd: 1'b0, line: tag_q};
                        state_q <= B_EVICT;
                     end else begin
                        burst_q <= '{rd: 1'b1, line: req_line};
                        state_q <= B_FILL;
                     end
                  end
               end
            end
            B_EVICT, B_FILL: begin
               if (burst_ack)
                  acked_q <= 1'b1;
               if ((state_q == B_EVICT && wr_rdy) || (state_q == B_FILL && rd_vld))
                  idx_q <= idx_q + 1'b1;
               if (burst_done) begin
                  burst_req <= 1'b0;
                  acked_q   <= 1'b0;
                  dirty_q   <= 1'b0;
                  if (state_q == B_FILL)
                     valid_q <= 1'b1;
                  state_q <= B_IDLE;   // Lookup again, fill or hit follows
               end
            end
            default: state_q <= B_IDLE;
         endcase
      end
   end

   // Line storage and data paths
   always_ff @(posedge clk) begin
      if (start && hit) begin
         rdata_q <= mem[req_idx];
         if (req.we) begin
            for (int b = 0; b < SEL_W; b++) begin
               if (req.sel[b])
                  mem[req_idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
         end
      end
      if (state_q == B_EVICT && wr_rdy)
         wr_data <= mem[idx_q];               // Next cycle after each wr_rdy
      if (state_q == B_FILL && rd_vld)
         mem[idx_q] <= rd_data;
      if (state_q == B_FILL && burst_done)
         tag_q <= burst_q.line;
   end

endmodule

/* verilog/sdram_ctrl.sv */
`timescale 1ns/1ns

module sdram_ctrl import sdr_pkg::*; #(
   parameter int T_RP       = 3,    // Min 2 for all timing values
   parameter int T_RCD      = 3,
   parameter int T_MRD      = 2,
   parameter int T_RFC      = 9,
   parameter int CAS_LAT    = 3,
   parameter int REF_SHIFT  = 9,    // Refresh every 2**REF_SHIFT clocks
   parameter int INIT_SHIFT = 15    // Power-up wait 2**INIT_SHIFT clocks
) (
   input  logic              clk,
   input  logic              rst_n,
   input  burst_cmd_t        burst,
   input  logic              burst_req,
   output logic              burst_ack,
   output logic              wr_rdy,
   input  logic [DATA_W-1:0] wr_data,
   output logic              rd_vld,
   output logic [DATA_W-1:0] rd_data,
   output sdr_cmd_t          sdr_cmd,
   output logic [SEL_W-1:0]  sdr_dqm,
   output logic              sdr_cke,
   inout  wire  [DATA_W-1:0] sdr_dq
);

   localparam int CNT_W = (INIT_SHIFT > REF_SHIFT ? INIT_SHIFT : REF_SHIFT) + 1;
   localparam int DLY_W = 7;
   localparam int BANKS = 1 << BA_W;
   localparam int BLEN  = 1 << LINE_LOG;

   typedef enum logic [2:0] {
      S_IDLE, S_NOP, S_PRECHARGE, S_LOAD_MODE, S_AUTO_REFRESH, S_RW, S_INIT_RW, S_END_RW
   } state_t;

   state_t                    state_q;
   state_t                    ret_q;         // Where the NOP wait goes next
   logic [DLY_W-1:0]          dly_q;
   logic [CNT_W-1:0]          cnt_q;         // Init wait and refresh tick
   logic                      rf_pend_q;
   logic                      init_done_q;
   logic [BANKS-1:0]          bank_act_q;
   logic [ROW_W-1:0]          open_row_q [BANKS];
   logic                      rd_q;
   logic [ROW_W-1:0]          row_q;
   logic [BA_W-1:0]           bank_q;
   logic [COL_W-LINE_LOG-1:0] col_q;
   logic [3:0]                op_q;
   logic [BA_W-1:0]           ba_q;
   logic [ROW_W-1:0]          addr_q;
   logic [DATA_W-1:0]         wd1_q;
   logic [DATA_W-1:0]         dq_out_q;
   logic [2:0]                oe_q;          // wr_rdy delayed to the WRITE cycle

   assign sdr_cmd = {op_q, ba_q, addr_q};
   assign sdr_cke = 1'b1;
   assign sdr_dq  = oe_q[2] ? dq_out_q : 'z;

   // Two flops from wr_data so word 0 meets the WRITE command
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         oe_q <= '0;
      else
         oe_q <= {oe_q[1:0], wr_rdy};
   end

   always_ff @(posedge clk) begin
      wd1_q    <= wr_data;
      dq_out_q <= wd1_q;
      rd_data  <= sdr_dq;      // Input flop, word k sampled CAS_LAT+k after READ edge
   end

   // Row opened by ACTIVE
   always_ff @(posedge clk) begin
      if (state_q == S_RW && !bank_act_q[bank_q])
         open_row_q[bank_q] <= row_q;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q     <= S_IDLE;
         ret_q       <= S_IDLE;
         dly_q       <= '0;
         cnt_q       <= '0;
         rf_pend_q   <= 1'b1;      // Init refreshes run until the tick bit matches
         init_done_q <= 1'b0;
         bank_act_q  <= '0;
         rd_q        <= 1'b0;
         row_q       <= '0;
         bank_q      <= '0;
         col_q       <= '0;
         op_q        <= CMD_NOP;
         ba_q        <= '0;
         addr_q      <= '0;
         sdr_dqm     <= '1;
         burst_ack   <= 1'b0;
         wr_rdy      <= 1'b0;
         rd_vld      <= 1'b0;
      end else begin
         cnt_q   <= cnt_q + 1'b1;
         dly_q   <= dly_q - 1'b1;
         op_q    <= CMD_NOP;
         state_q <= S_NOP;
         case (state_q)
            S_IDLE: begin
               if (!init_done_q) begin
                  state_q <= cnt_q[INIT_SHIFT] ? S_PRECHARGE : S_IDLE;   // Power-up wait
               end else if (rf_pend_q != cnt_q[REF_SHIFT]) begin
                  rf_pend_q <= cnt_q[REF_SHIFT];                      // Refresh wins
                  state_q   <= S_PRECHARGE;
               end else if (burst_req) begin
                  burst_ack                <= 1'b1;
                  rd_q                     <= burst.rd;
                  {row_q, bank_q, col_q}   <= burst.line;
                  state_q                  <= S_RW;
               end else begin
                  state_q <= S_IDLE;
               end
            end
            S_NOP: begin
               // Stop the pull two cycles before the burst ends
               if (ret_q == S_END_RW && dly_q == DLY_W'(2))
                  wr_rdy <= 1'b0;
               if (dly_q == '0)
                  state_q <= ret_q;
            end
            S_PRECHARGE: begin
               op_q       <= CMD_PRECHARGE;
               addr_q[10] <= 1'b1;                 // All banks
               ret_q      <= init_done_q ? S_AUTO_REFRESH : S_LOAD_MODE;
               dly_q      <= DLY_W'(T_RP - 2);
               bank_act_q <= '0;
            end
            S_LOAD_MODE: begin
               op_q   <= CMD_LOAD_MODE;
               // Full page, sequential, CAS_LAT, burst write
               addr_q <= ROW_W'(7 + (CAS_LAT << 4));
               ba_q   <= '0;
               ret_q  <= S_AUTO_REFRESH;
               dly_q  <= DLY_W'(T_MRD - 2);
            end
            S_AUTO_REFRESH: begin
               op_q <= CMD_REFRESH;
               if (rf_pend_q != cnt_q[REF_SHIFT]) begin
                  ret_q <= S_AUTO_REFRESH;       // Another one, init only
               end else begin
                  init_done_q <= 1'b1;
                  sdr_dqm     <= '0;
                  ret_q       <= S_IDLE;
               end
               dly_q <= DLY_W'(T_RFC - 2);
            end
            S_RW: begin
               ba_q <= bank_q;
               if (!bank_act_q[bank_q]) begin
                  op_q               <= CMD_ACTIVE;
                  addr_q             <= row_q;
                  bank_act_q[bank_q] <= 1'b1;
                  ret_q              <= S_RW;
                  dly_q              <= DLY_W'(T_RCD - 2);
               end else if (open_row_q[bank_q] != row_q) begin
                  // Wrong row open, close this bank only
                  op_q               <= CMD_PRECHARGE;
                  addr_q[10]         <= 1'b0;
                  bank_act_q[bank_q] <= 1'b0;
                  ret_q              <= S_RW;
                  dly_q              <= DLY_W'(T_RP - 2);
               end else begin
                  addr_q <= ROW_W'({col_q, {LINE_LOG{1'b0}}});   // A10 low, no auto precharge
                  ret_q  <= S_INIT_RW;
                  if (rd_q) begin
                     op_q  <= CMD_READ;
                     dly_q <= DLY_W'(CAS_LAT - 1);
                  end else begin
                     wr_rdy <= 1'b1;          // Data pipe fills before WRITE
                     dly_q  <= DLY_W'(1);
                  end
               end
            end
            S_INIT_RW: begin
               if (rd_q)
                  rd_vld <= 1'b1;             // First word reaches rd_data now
               else
                  op_q <= CMD_WRITE;
               ret_q <= S_END_RW;
               dly_q <= DLY_W'(BLEN - 2);
            end
            S_END_RW: begin
               op_q      <= CMD_BURST_TERM;   // Cut the full-page burst at 8
               burst_ack <= 1'b0;
               rd_vld    <= 1'b0;
               ret_q     <= S_IDLE;
               dly_q     <= DLY_W'(2);
            end
         endcase
      end
   end

endmodule

/* verilog/sdr_subsys_top.sv */
`timescale 1ns/1ns

module sdr_subsys_top import sdr_pkg::*; #(
   parameter int T_RP       = 3,
   parameter int T_RCD      = 3,
   parameter int T_MRD      = 2,
   parameter int T_RFC      = 9,
   parameter int CAS_LAT    = 3,
   parameter int REF_SHIFT  = 9,
   parameter int INIT_SHIFT = 15
) (
   input  logic              clk,
   input  logic              rst_n,
   // Wishbone classic slave
   input  logic              wb_cyc,
   input  logic              wb_stb,
   input  logic              wb_we,
   input  logic [ADDR_W-1:0] wb_adr,
   input  logic [SEL_W-1:0]  wb_sel,
   input  logic [DATA_W-1:0] wb_dat_w,
   output logic [DATA_W-1:0] wb_dat_r,
   output logic              wb_ack,
   // SDRAM pins
   output sdr_cmd_t          sdr_cmd,
   output logic [SEL_W-1:0]  sdr_dqm,
   output logic              sdr_cke,
   inout  wire  [DATA_W-1:0] sdr_dq
);

   cpu_req_t          req;
   logic              req_valid;
   cpu_rsp_t          rsp;
   burst_cmd_t        burst;
   logic              burst_req;
   logic              burst_ack;
   logic              wr_rdy;
   logic [DATA_W-1:0] wr_data;
   logic              rd_vld;
   logic [DATA_W-1:0] rd_data;

   wb_slave_port u_port (
      .clk       (clk),
      .rst_n     (rst_n),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_sel    (wb_sel),
      .wb_dat_w  (wb_dat_w),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack),
      .req       (req),
      .req_valid (req_valid),
      .rsp       (rsp)
   );

   line_buffer u_buf (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .req_valid (req_valid),
      .rsp       (rsp),
      .burst     (burst),
      .burst_req (burst_req),
      .burst_ack (burst_ack),
      .wr_rdy    (wr_rdy),
      .wr_data   (wr_data),
      .rd_vld    (rd_vld),
      .rd_data   (rd_data)
   );

   sdram_ctrl #(
      .T_RP       (T_RP),
      .T_RCD      (T_RCD),
      .T_MRD      (T_MRD),
      .T_RFC      (T_RFC),
      .CAS_LAT    (CAS_LAT),
      .REF_SHIFT  (REF_SHIFT),
      .INIT_SHIFT (INIT_SHIFT)
   ) u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .burst     (burst),
      .burst_req (burst_req),
      .burst_ack (burst_ack),
      .wr_rdy    (wr_rdy),
      .wr_data   (wr_data),
      .rd_vld    (rd_vld),
      .rd_data   (rd_data),
      .sdr_cmd   (sdr_cmd),
      .sdr_dqm   (sdr_dqm),
      .sdr_cke   (sdr_cke),
      .sdr_dq    (sdr_dq)
   );

endmodule

/* test/clk_gen.sv */
`timescale 1ns/1ns

module clk_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // 20 ns period
   end

   initial begin
      rst_n = 1'b0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

/* test/sdram_model.sv */
`timescale 1ns/1ns

module sdram_model import sdr_pkg::*; #(
   parameter int CAS_LAT = 3
) (
   input  logic             clk,
   input  sdr_cmd_t         cmd,
   input  logic [SEL_W-1:0] dqm,
   inout  wire [DATA_W-1:0] dq,
   output logic             cmd_error
);

   logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];   // Sparse, only written words
   logic [3:0]        open_q;                    // Bank has an open row
   logic [ROW_W-1:0]  row_q [4];
   int                rd_cnt, rd_dly, wr_cnt;
   logic [ROW_W-1:0]  rd_row, wr_row;
   logic [BA_W-1:0]   rd_ba, wr_ba;
   logic [COL_W-1:0]  rd_col, wr_col;
   logic              dq_oe;
   logic [DATA_W-1:0] dq_val;

   assign dq = dq_oe ? dq_val : 'z;

   // Contents before any write, depends on every address bit
   function automatic logic [DATA_W-1:0] preload_word(input logic [ADDR_W-1:0] a);
      return a[15:0] ^ {a[23:16], a[23:16]} ^ 16'h5a3c;
   endfunction

   function automatic logic [DATA_W-1:0] peek(input logic [ADDR_W-1:0] a);
      if (mem.exists(a))
         return mem[a];
      return preload_word(a);
   endfunction

   task automatic store_word(input logic [ADDR_W-1:0] a);
      logic [DATA_W-1:0] old;
      old = peek(a);
      mem[a] = {dqm[1] ? old[15:8] : dq[15:8], dqm[0] ? old[7:0] : dq[7:0]};
   endtask

   task automatic report_error(input string what);
      $display("SDRAM model: %s at %0t", what, $time);
      cmd_error <= 1'b1;
   endtask

   initial begin
      cmd_error = 1'b0;
      dq_oe     = 1'b0;
      dq_val    = '0;
      open_q    = '0;
      rd_cnt    = 0;
      rd_dly    = 0;
      wr_cnt    = 0;
   end

   always @(posedge clk) begin
      logic [3:0] op;
      op = {cmd.cs_n, cmd.ras_n, cmd.cas_n, cmd.we_n};
      // Remaining words of a write burst
      if (wr_cnt != 0) begin
         store_word({wr_row, wr_ba, wr_col});
         wr_col = wr_col + 1'b1;
         wr_cnt = wr_cnt - 1;
      end
      // Read pipeline, word k valid at READ edge + CAS_LAT + k
      if (rd_cnt != 0) begin
         if (rd_dly != 0) begin
            rd_dly = rd_dly - 1;
         end else begin
            dq_oe  <= 1'b1;
            dq_val <= peek({rd_row, rd_ba, rd_col});
            rd_col = rd_col + 1'b1;
            rd_cnt = rd_cnt - 1;
         end
      end else begin
         dq_oe <= 1'b0;
      end
      case (op)
         CMD_ACTIVE: begin
            if (open_q[cmd.ba])
               report_error("ACTIVE to a bank that already has an open row");
            open_q[cmd.ba] = 1'b1;
            row_q[cmd.ba]  = cmd.addr;
         end
         CMD_PRECHARGE: begin
            if (cmd.addr[10])
               open_q = '0;          // All banks
            else
               open_q[cmd.ba] = 1'b0;
         end
         CMD_READ: begin
            if (!open_q[cmd.ba])
               report_error("READ to a bank with no open row");
            rd_row = row_q[cmd.ba];
            rd_ba  = cmd.ba;
            rd_col = cmd.addr[COL_W-1:0];
            rd_dly = CAS_LAT - 2;
            rd_cnt = 8;
         end
         CMD_WRITE: begin
            if (!open_q[cmd.ba])
               report_error("WRITE to a bank with no open row");
            wr_row = row_q[cmd.ba];
            wr_ba  = cmd.ba;
            wr_col = cmd.addr[COL_W-1:0];
            store_word({wr_row, wr_ba, wr_col});   // Word 0 comes with the command
            wr_col = wr_col + 1'b1;
            wr_cnt = 7;
         end
         default: ;
      endcase
   end

endmodule

/* test/tb_sdr_subsys.sv */
`timescale 1ns/1ns

module tb_sdr_subsys import sdr_pkg::*; ();

   localparam int INIT_SHIFT = 6;
   localparam int REF_SHIFT  = 9;
   localparam int CAS_LAT    = 3;
   localparam int MAX_CYCLES = 20000;   // About twice the full run

   logic              clk, rst_n;
   logic              wb_cyc, wb_stb, wb_we, wb_ack;
   logic [ADDR_W-1:0] wb_adr;
   logic [SEL_W-1:0]  wb_sel;
   logic [DATA_W-1:0] wb_dat_w, wb_dat_r;
   sdr_cmd_t          sdr_cmd;
   logic [SEL_W-1:0]  sdr_dqm;
   logic              sdr_cke, cmd_error;
   wire  [DATA_W-1:0] sdr_dq;

   logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];   // Expected SDRAM contents
   logic [31:0]       lcg_state = 32'd15189;
   int                cycles = 0;
   int                n_cmd = 0;
   int                ref_cnt = 0;
   logic [3:0]        first_op [3];
   logic [ROW_W-1:0]  first_addr [3];
   logic              ack_early = 1'b0;

   clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

   sdr_subsys_top #(
      .CAS_LAT    (CAS_LAT),
      .REF_SHIFT  (REF_SHIFT),
      .INIT_SHIFT (INIT_SHIFT)
   ) u_sdr_subsys_top (
      .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(wb_adr), .wb_sel(wb_sel), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
      .wb_ack(wb_ack), .sdr_cmd(sdr_cmd), .sdr_dqm(sdr_dqm), .sdr_cke(sdr_cke),
      .sdr_dq(sdr_dq)
   );

   sdram_model #(.CAS_LAT(CAS_LAT)) u_model (
      .clk(clk), .cmd(sdr_cmd), .dqm(sdr_dqm), .dq(sdr_dq), .cmd_error(cmd_error)
   );

   task automatic stop_with_failure();
      $display("TB FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
         stop_with_failure();
      end
   endtask

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Same preload rule as the SDRAM model
   function automatic logic [DATA_W-1:0] initial_word(input logic [ADDR_W-1:0] a);
      return a[15:0] ^ {a[23:16], a[23:16]} ^ 16'h5a3c;
   endfunction

   function automatic logic [DATA_W-1:0] expected(input logic [ADDR_W-1:0] a);
      if (ref_mem.exists(a))
         return ref_mem[a];
      return initial_word(a);
   endfunction

   function automatic logic [ADDR_W-1:0] make_addr(input int row, input int bank, input int col);
      return {ROW_W'(row), BA_W'(bank), COL_W'(col)};
   endfunction

   // Bus monitor, cycle limit and model errors
   always @(negedge clk) begin
      logic [3:0] op;
      op = {sdr_cmd.cs_n, sdr_cmd.ras_n, sdr_cmd.cas_n, sdr_cmd.we_n};
      if (rst_n) begin
         cycles++;
         check("sdr_cke", sdr_cke, 1'b1);   // No power-down
         if (op != CMD_NOP && n_cmd < 3) begin
            first_op[n_cmd]   = op;
            first_addr[n_cmd] = sdr_cmd.addr;
            n_cmd++;
         end
         if (op == CMD_REFRESH)
            ref_cnt++;
         if (wb_ack && sdr_dqm == '1)
            ack_early = 1'b1;     // dqm stays all ones until init is over
      end
      if (cmd_error)
         stop_with_failure();
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: no end of test after %0d cycles", MAX_CYCLES);
         stop_with_failure();
      end
   end

   task automatic wb_cycle(input logic we, input logic [ADDR_W-1:0] adr,
                           input logic [SEL_W-1:0] sel, input logic [DATA_W-1:0] dat,
                           output logic [DATA_W-1:0] rdata);
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_sel   <= sel;
      wb_dat_w <= dat;
      @(negedge clk);
      while (!wb_ack)
         @(negedge clk);
      rdata = wb_dat_r;
      @(posedge clk);
      wb_cyc <= 1'b0;     // Stb drops in the cycle after ack
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic write_word(input logic [ADDR_W-1:0] adr, input logic [SEL_W-1:0] sel,
                             input logic [DATA_W-1:0] dat);
      logic [DATA_W-1:0] old, unused;
      old = expected(adr);
      ref_mem[adr] = {sel[1] ? dat[15:8] : old[15:8], sel[0] ? dat[7:0] : old[7:0]};
      wb_cycle(1'b1, adr, sel, dat, unused);
   endtask

   task automatic read_check(input logic [ADDR_W-1:0] adr);
      logic [DATA_W-1:0] rdata;
      wb_cycle(1'b0, adr, '0, '0, rdata);
      check("wb_dat_r", rdata, expected(adr));
   endtask

   task automatic init_sequence();
      write_word(make_addr(2, 0, 16), 2'b11, 16'h1357);   // Held off until init ends
      check("first_cmd", first_op[0], CMD_PRECHARGE);
      check("precharge_a10", first_addr[0][10], 1'b1);
      check("second_cmd", first_op[1], CMD_LOAD_MODE);
      check("mode_value", first_addr[1], 7 + CAS_LAT * 16);
      check("third_cmd", first_op[2], CMD_REFRESH);
      check("ack_during_init", ack_early, 1'b0);
   endtask

   task automatic hit_write_read();
      write_word(make_addr(2, 0, 17), 2'b11, 16'ha5c3);
      read_check(make_addr(2, 0, 17));
      read_check(make_addr(2, 0, 16));
      read_check(make_addr(2, 0, 20));    // Untouched word of the same line
   endtask

   task automatic byte_select_merge();
      logic [DATA_W-1:0] rdata;
      write_word(make_addr(2, 0, 18), 2'b11, 16'h0000);
      write_word(make_addr(2, 0, 18), 2'b01, 16'h12ab);
      write_word(make_addr(2, 0, 18), 2'b10, 16'hcd34);
      wb_cycle(1'b0, make_addr(2, 0, 18), '0, '0, rdata);
      check("wb_dat_r", rdata, 16'hcdab);
   endtask

   task automatic dirty_eviction();
      write_word(make_addr(5, 1, 64), 2'b11, 16'hbeef);
      for (int i = 0; i < 8; i++)
         read_check(make_addr(9, 1, 128 + i));   // Another row in the same bank
      check("model_mem", u_model.peek(make_addr(5, 1, 64)), 16'hbeef);
   endtask

   task automatic random_traffic();
      logic [31:0] r;
      int row, bank, line;
      row  = 0;
      bank = 0;
      line = 0;
      for (int n = 0; n < 200; n++) begin
         r = next_random();
         if (r[17:16] == 2'b00) begin    // Stay in the current line most of the time
            row  = int'(r[21:20]) + 12;
            bank = int'(r[23:22]);
            line = int'(r[27:24]);
         end
         r = next_random();
         if (r[16])
            write_word(make_addr(row, bank, line * 8 + int'(r[19:17])),
                       r[21:20] == 2'b00 ? 2'b11 : r[21:20], r[31:16] ^ r[15:0]);
         else
            read_check(make_addr(row, bank, line * 8 + int'(r[19:17])));
      end
   endtask

   task automatic idle_refresh();
      int start;
      start = ref_cnt;
      repeat (4096) @(negedge clk);
      check("refresh_count_ok", (ref_cnt - start) >= (4096 >> REF_SHIFT) - 1, 1'b1);
   endtask

   initial begin
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_sel   = '0;
      wb_dat_w = '0;
      wait (rst_n);
      init_sequence();
      hit_write_read();
      byte_select_merge();
      dirty_eviction();
      random_traffic();
      idle_refresh();
      $display("TB PASSED");
      $finish;
   end

endmodule

/* verilog.f */
verilog/sdr_pkg.sv
verilog/wb_slave_port.sv
verilog/line_buffer.sv
verilog/sdram_ctrl.sv
verilog/sdr_subsys_top.sv
test/clk_gen.sv
test/sdram_model.sv
test/tb_sdr_subsys.sv

/* Makefile */
TOP = tb_sdr_subsys

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f verilog.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -Wno-fatal -f verilog.f --top-module $(TOP)
	verilator --lint-only -Wall -Wno-fatal -f verilog.f --top-module sdr_subsys_top

clean:
	rm -rf obj_dir sim.log
